//--- verilog/link_pkg.sv
package link_pkg;

	////////////////////////////////////////
	// Stream word and flag layout
	////////////////////////////////////////
	localparam int WORD_W = 32;
	localparam int FLAG_W = 4;

	// Flag bit positions, bits 2 and 3 stay zero
	localparam int FLAG_SOF = 0;
	localparam int FLAG_EOF = 1;

	// Header tags, upper half of word 0
	localparam logic [15:0] TAG_PRI = 16'hC0F0;
	localparam logic [15:0] TAG_SEC = 16'hADC0;

	////////////////////////////////////////
	// Serial mux link
	////////////////////////////////////////
	localparam int MUX_W = 8;
	localparam logic [MUX_W-1:0] SYNC_IDLE = 8'h01;
	localparam logic [MUX_W-1:0] SYNC_LOCK = 8'h81;

	// Defaults only, the top level overrides these
	localparam int PRI_PKT_WORDS_DEF = 4;
	localparam int SEC_PKT_WORDS_DEF = 8;
	localparam int FIFO_AW_DEF = 4;

endpackage

//--- verilog/word_fifo.sv
module word_fifo import link_pkg::*; #(
	parameter int PKT_WORDS = PRI_PKT_WORDS_DEF,
	parameter int FIFO_AW = FIFO_AW_DEF
) (
	input  logic              GMII_GTX_CLK_int,
	input  logic              dsp_rst,
	input  logic              we_i,
	input  logic [WORD_W-1:0] din_i,
	input  logic              rd_i,
	output logic [WORD_W-1:0] dout_o,
	output logic              pkt_avail_o,
	output logic              ovf_o
);

	localparam int DEPTH = 1 << FIFO_AW;

	// Circular buffer storage
	logic [WORD_W-1:0] mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	// One extra bit so a full buffer is distinct from empty
	logic [FIFO_AW:0] count;
	logic wr_ok;
	logic rd_ok;

	// Writes into a full buffer are lost
	assign wr_ok = we_i && (count != (FIFO_AW+1)'(DEPTH));
	// Reads of an empty buffer are ignored
	assign rd_ok = rd_i && (count != '0);

	// Head word shown without read latency
	assign dout_o = mem[rd_ptr];
	// Enough words stored for a whole packet
	assign pkt_avail_o = (count >= (FIFO_AW+1)'(PKT_WORDS));

	// Storage array
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (wr_ok)
			mem[wr_ptr] <= din_i;
	end

	// Pointers, fill level, overflow pulse
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			ovf_o <= 1'b0;
		end else begin
			ovf_o <= we_i && !wr_ok;
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			// Read and write together leave the count alone
			case ({wr_ok, rd_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/packet_sender.sv
module packet_sender import link_pkg::*; #(
	parameter int PRI_PKT_WORDS = PRI_PKT_WORDS_DEF,
	parameter int SEC_PKT_WORDS = SEC_PKT_WORDS_DEF
) (
	input  logic              GMII_GTX_CLK_int,
	input  logic              dsp_rst,
	input  logic              pri_avail_i,
	input  logic [WORD_W-1:0] pri_d_i,
	input  logic              sec_avail_i,
	input  logic [WORD_W-1:0] sec_d_i,
	input  logic              tx_dst_rdy_i,
	output logic              pri_rd_o,
	output logic              sec_rd_o,
	output logic [WORD_W-1:0] tx_data_o,
	output logic [FLAG_W-1:0] tx_flags_o,
	output logic              tx_src_rdy_o
);

	localparam int MAX_WORDS = (PRI_PKT_WORDS > SEC_PKT_WORDS) ? PRI_PKT_WORDS : SEC_PKT_WORDS;
	localparam int CNT_W = $clog2(MAX_WORDS + 1);
	// Index of the last payload word per source
	localparam logic [CNT_W-1:0] PRI_LAST = CNT_W'(PRI_PKT_WORDS - 1);
	localparam logic [CNT_W-1:0] SEC_LAST = CNT_W'(SEC_PKT_WORDS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_PAYLOAD
	} state_t;

	state_t state;
	// High when the secondary source owns the packet
	logic src_sec;
	logic [CNT_W-1:0] pay_cnt;
	logic [15:0] pri_seq;
	logic [15:0] sec_seq;
	logic last_word;
	logic take_word;

	////////////////////////////////////////
	// Handshake and FIFO reads
	////////////////////////////////////////
	assign last_word = src_sec ? (pay_cnt == SEC_LAST) : (pay_cnt == PRI_LAST);
	// Payload word accepted downstream
	assign take_word = (state == ST_PAYLOAD) && tx_dst_rdy_i;
	assign pri_rd_o = take_word && !src_sec;
	assign sec_rd_o = take_word && src_sec;
	assign tx_src_rdy_o = (state != ST_IDLE);

	// Header is tag over sequence, payload is the FIFO head
	always_comb begin
		tx_data_o = '0;
		tx_flags_o = '0;
		case (state)
			ST_HEADER: begin
				tx_data_o = src_sec ? {TAG_SEC, sec_seq} : {TAG_PRI, pri_seq};
				tx_flags_o[FLAG_SOF] = 1'b1;
			end
			ST_PAYLOAD: begin
				tx_data_o = src_sec ? sec_d_i : pri_d_i;
				tx_flags_o[FLAG_EOF] = last_word;
			end
			default: begin
				tx_data_o = '0;
			end
		endcase
	end

	////////////////////////////////////////
	// Framing FSM
	////////////////////////////////////////
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			state <= ST_IDLE;
			src_sec <= 1'b0;
			pay_cnt <= '0;
			pri_seq <= '0;
			sec_seq <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					pay_cnt <= '0;
					// Primary wins at every boundary
					if (pri_avail_i) begin
						src_sec <= 1'b0;
						state <= ST_HEADER;
					end else if (sec_avail_i) begin
						src_sec <= 1'b1;
						state <= ST_HEADER;
					end
				end
				ST_HEADER: begin
					if (tx_dst_rdy_i) begin
						state <= ST_PAYLOAD;
						// Sequence moves once the header is gone
						if (src_sec)
							sec_seq <= sec_seq + 1'b1;
						else
							pri_seq <= pri_seq + 1'b1;
					end
				end
				ST_PAYLOAD: begin
					if (tx_dst_rdy_i) begin
						// Back to idle so the FIFO count settles before arbitration
						if (last_word)
							state <= ST_IDLE;
						else
							pay_cnt <= pay_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/link_sync.sv
module link_sync import link_pkg::*; (
	input  logic             GMII_GTX_CLK_int,
	input  logic             dsp_rst,
	input  logic [MUX_W-1:0] mux_in_i,
	input  logic [6:0]       sw_i,
	output logic [MUX_W-1:0] mux_out_o,
	output logic             bitslip_o,
	output logic             synced_o
);

	// Pattern sent while hunting
	logic [MUX_W-1:0] sync_pattern;
	// Toggles every cycle so the far end can spot a dead link
	logic toggle;
	// Bit 7 value expected on the next word
	logic mon_expect;
	logic mon_valid;
	// Delayed bitslip, spaces the requests
	logic bitslip_d;
	logic aligned;

	// Input is one of the two hunt patterns
	assign aligned = (mux_in_i == SYNC_IDLE) || (mux_in_i == SYNC_LOCK);

	// Toggle bit above the switches once synced
	assign mux_out_o = synced_o ? {toggle, sw_i} : sync_pattern;

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			toggle <= 1'b0;
			synced_o <= 1'b0;
			bitslip_o <= 1'b0;
			bitslip_d <= 1'b0;
			mon_valid <= 1'b0;
			mon_expect <= 1'b0;
			sync_pattern <= SYNC_IDLE;
		end else begin
			toggle <= !toggle;
			bitslip_d <= bitslip_o;
			// Bitslip is a single-cycle request
			bitslip_o <= 1'b0;
			if (synced_o) begin
				////////////////////////////////////////
				// Link-loss monitor
				////////////////////////////////////////
				if (mon_valid) begin
					if (mon_expect == mux_in_i[7]) begin
						mon_expect <= !mux_in_i[7];
					end else begin
						// Far end stopped toggling
						mon_valid <= 1'b0;
						synced_o <= 1'b0;
					end
				end else if (mux_in_i != SYNC_LOCK) begin
					// First live word arms the monitor
					mon_expect <= !mux_in_i[7];
					mon_valid <= 1'b1;
				end
			end else if (!aligned) begin
				////////////////////////////////////////
				// Hunting
				////////////////////////////////////////
				sync_pattern <= SYNC_IDLE;
				// Two idle cycles after the previous slip
				if (!bitslip_o && !bitslip_d)
					bitslip_o <= 1'b1;
			end else begin
				// Lock seen twice, the far end agrees
				if (mux_in_i == SYNC_LOCK && sync_pattern == SYNC_LOCK)
					synced_o <= 1'b1;
				sync_pattern <= SYNC_LOCK;
			end
		end
	end

endmodule

//--- verilog/eth_adc_top.sv
module eth_adc_top import link_pkg::*; #(
	parameter int PRI_PKT_WORDS = PRI_PKT_WORDS_DEF,
	parameter int SEC_PKT_WORDS = SEC_PKT_WORDS_DEF,
	parameter int FIFO_AW = FIFO_AW_DEF
) (
	input  logic              GMII_GTX_CLK_int,
	input  logic              dsp_rst,
	// Configuration words
	input  logic [WORD_W-1:0] pri_data_i,
	input  logic              pri_we_i,
	output logic              pri_ovf_o,
	// ADC sample words
	input  logic [WORD_W-1:0] sec_data_i,
	input  logic              sec_we_i,
	output logic              sec_ovf_o,
	// Flagged stream towards the MAC
	output logic [WORD_W-1:0] tx_data_o,
	output logic [FLAG_W-1:0] tx_flags_o,
	output logic              tx_src_rdy_o,
	input  logic              tx_dst_rdy_i,
	// Serial mux link
	input  logic [MUX_W-1:0]  mux_in_i,
	input  logic [6:0]        sw_i,
	output logic [MUX_W-1:0]  mux_out_o,
	output logic              bitslip_o,
	output logic              synced_o
);

	logic [WORD_W-1:0] pri_d;
	logic [WORD_W-1:0] sec_d;
	logic pri_avail;
	logic sec_avail;
	logic pri_rd;
	logic sec_rd;

	////////////////////////////////////////
	// Source buffers
	////////////////////////////////////////
	word_fifo #(.PKT_WORDS(PRI_PKT_WORDS), .FIFO_AW(FIFO_AW)) u_pri_fifo (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.dsp_rst(dsp_rst),
		.we_i(pri_we_i),
		.din_i(pri_data_i),
		.rd_i(pri_rd),
		.dout_o(pri_d),
		.pkt_avail_o(pri_avail),
		.ovf_o(pri_ovf_o)
	);

	word_fifo #(.PKT_WORDS(SEC_PKT_WORDS), .FIFO_AW(FIFO_AW)) u_sec_fifo (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.dsp_rst(dsp_rst),
		.we_i(sec_we_i),
		.din_i(sec_data_i),
		.rd_i(sec_rd),
		.dout_o(sec_d),
		.pkt_avail_o(sec_avail),
		.ovf_o(sec_ovf_o)
	);

	// Packet framing onto the stream
	packet_sender #(
		.PRI_PKT_WORDS(PRI_PKT_WORDS),
		.SEC_PKT_WORDS(SEC_PKT_WORDS)
	) u_packet_sender (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.dsp_rst(dsp_rst),
		.pri_avail_i(pri_avail),
		.pri_d_i(pri_d),
		.sec_avail_i(sec_avail),
		.sec_d_i(sec_d),
		.tx_dst_rdy_i(tx_dst_rdy_i),
		.pri_rd_o(pri_rd),
		.sec_rd_o(sec_rd),
		.tx_data_o(tx_data_o),
		.tx_flags_o(tx_flags_o),
		.tx_src_rdy_o(tx_src_rdy_o)
	);

	// Mux link alignment and monitor
	link_sync u_link_sync (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.dsp_rst(dsp_rst),
		.mux_in_i(mux_in_i),
		.sw_i(sw_i),
		.mux_out_o(mux_out_o),
		.bitslip_o(bitslip_o),
		.synced_o(synced_o)
	);

endmodule

//--- tests/tb_props.sv
module tb_props import link_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              src_rdy_i,
	input  logic              dst_rdy_i,
	input  logic [WORD_W-1:0] data_i,
	input  logic [FLAG_W-1:0] flags_i,
	input  logic              bitslip_i
);

	// Assertion failure count
	int fail_cnt = 0;

	// Stalled word holds still
	a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		src_rdy_i && !dst_rdy_i |=> $stable(data_i) && $stable(flags_i))
	else begin
		$error("stream word or flags changed while stalled");
		fail_cnt++;
	end

	// At most one bitslip in any three cycles
	a_slip: assert property (@(posedge clk_i) disable iff (rst_i)
		bitslip_i |=> !bitslip_i ##1 !bitslip_i)
	else begin
		$error("bitslip requests too close together");
		fail_cnt++;
	end

	// Start and end never share a word
	a_flags: assert property (@(posedge clk_i) disable iff (rst_i)
		!(flags_i[FLAG_SOF] && flags_i[FLAG_EOF]))
	else begin
		$error("SOF and EOF set on the same word");
		fail_cnt++;
	end

endmodule

////////////////////////////////////////
// Attach to the sender and link monitor
////////////////////////////////////////
bind packet_sender tb_props u_props_tx (
	.clk_i(GMII_GTX_CLK_int),
	.rst_i(dsp_rst),
	.src_rdy_i(tx_src_rdy_o),
	.dst_rdy_i(tx_dst_rdy_i),
	.data_i(tx_data_o),
	.flags_i(tx_flags_o),
	.bitslip_i(1'b0)
);

bind link_sync tb_props u_props_link (
	.clk_i(GMII_GTX_CLK_int),
	.rst_i(dsp_rst),
	.src_rdy_i(1'b0),
	.dst_rdy_i(1'b1),
	.data_i('0),
	.flags_i('0),
	.bitslip_i(bitslip_o)
);

//--- tests/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 10,
	parameter int RST_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_o
);

	// Free running clock
	initial clk_o = 1'b0;
	always #(PERIOD / 2) clk_o = ~clk_o;

	// Reset held over the first edges, dropped just after an edge
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_o = 1'b0;
	end

endmodule

//--- tests/tb_checker.sv
module tb_checker import link_pkg::*; #(
	parameter int PRI_WORDS = PRI_PKT_WORDS_DEF,
	parameter int SEC_WORDS = SEC_PKT_WORDS_DEF,
	parameter int DEPTH = 16
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              pri_we_i,
	input  logic [WORD_W-1:0] pri_data_i,
	input  logic              pri_ovf_i,
	input  logic              sec_we_i,
	input  logic [WORD_W-1:0] sec_data_i,
	input  logic              sec_ovf_i,
	input  logic [WORD_W-1:0] tx_data_i,
	input  logic [FLAG_W-1:0] tx_flags_i,
	input  logic              tx_src_rdy_i,
	input  logic              tx_dst_rdy_i,
	input  logic [MUX_W-1:0]  mux_in_i,
	input  logic              bitslip_i,
	input  logic              synced_i,
	input  logic [MUX_W-1:0]  mux_out_i,
	input  logic              exp_valid_i,
	input  logic              exp_synced_i,
	input  logic [MUX_W-1:0]  exp_mux_i,
	input  logic [MUX_W-1:0]  exp_mask_i,
	output logic              idle_o
);

	string test_name = "reset";
	int value_errs;
	int proto_errs;
	// Words each FIFO should hold
	logic [WORD_W-1:0] pri_q[$];
	logic [WORD_W-1:0] sec_q[$];
	// Packet in progress, its source and word position
	logic busy;
	logic cur_sec;
	int pos;
	logic [15:0] pri_seq;
	logic [15:0] sec_seq;
	// Write dropped on the last edge
	logic pri_drop;
	logic sec_drop;
	// Predicted link state
	logic lnk_synced;
	logic lnk_lock;
	logic lnk_armed;
	logic lnk_expect;
	// Predicted bitslip now and one cycle back
	logic slip_exp;
	logic slip_exp_d;

	task automatic report_value(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("CHECK FAILED test %s: %s expected %h actual %h",
			test_name, what, exp_v, act_v);
		value_errs++;
	endtask

	always @(posedge clk_i) begin : check_proc
		logic [WORD_W-1:0] exp_data;
		logic [FLAG_W-1:0] exp_flags;
		logic was_busy;
		logic last;
		logic slip_next;
		if (rst_i) begin
			pri_q.delete();
			sec_q.delete();
			busy = 1'b0;
			cur_sec = 1'b0;
			pos = 0;
			pri_seq = '0;
			sec_seq = '0;
			pri_drop = 1'b0;
			sec_drop = 1'b0;
			lnk_synced = 1'b0;
			lnk_lock = 1'b0;
			lnk_armed = 1'b0;
			lnk_expect = 1'b0;
			slip_exp = 1'b0;
			slip_exp_d = 1'b0;
		end else begin
			was_busy = busy;
			// Stream valid only inside a packet
			if (tx_src_rdy_i !== busy)
				report_value("tx_src_rdy_o", busy, tx_src_rdy_i);
			// Overflow pulse follows a dropped write
			if (pri_ovf_i !== pri_drop)
				report_value("pri_ovf_o", pri_drop, pri_ovf_i);
			if (sec_ovf_i !== sec_drop)
				report_value("sec_ovf_o", sec_drop, sec_ovf_i);

			////////////////////////////////////////
			// Boundary arbitration, primary first
			////////////////////////////////////////
			if (!busy) begin
				pos = 0;
				if (pri_q.size() >= PRI_WORDS) begin
					busy = 1'b1;
					cur_sec = 1'b0;
				end else if (sec_q.size() >= SEC_WORDS) begin
					busy = 1'b1;
					cur_sec = 1'b1;
				end
			end

			// Writes judged against the fill before this edge
			pri_drop = pri_we_i && (pri_q.size() >= DEPTH);
			sec_drop = sec_we_i && (sec_q.size() >= DEPTH);
			if (pri_we_i && !pri_drop)
				pri_q.push_back(pri_data_i);
			if (sec_we_i && !sec_drop)
				sec_q.push_back(sec_data_i);

			////////////////////////////////////////
			// Transferred word
			////////////////////////////////////////
			if (tx_src_rdy_i && tx_dst_rdy_i && !was_busy) begin
				$display("Error in test %s: a word moved while no packet was due", test_name);
				proto_errs++;
			end else if (tx_src_rdy_i && tx_dst_rdy_i) begin
				exp_flags = '0;
				last = 1'b0;
				if (pos == 0) begin
					// Header, tag over per-source sequence
					exp_data = cur_sec ? {TAG_SEC, sec_seq} : {TAG_PRI, pri_seq};
					exp_flags[FLAG_SOF] = 1'b1;
					if (cur_sec)
						sec_seq = sec_seq + 1'b1;
					else
						pri_seq = pri_seq + 1'b1;
				end else if (cur_sec) begin
					exp_data = sec_q.pop_front();
					last = (pos == SEC_WORDS);
				end else begin
					exp_data = pri_q.pop_front();
					last = (pos == PRI_WORDS);
				end
				exp_flags[FLAG_EOF] = last;
				if (tx_data_i !== exp_data)
					report_value("tx_data_o", exp_data, tx_data_i);
				if (tx_flags_i !== exp_flags)
					report_value("tx_flags_o", exp_flags, tx_flags_i);
				if (last)
					busy = 1'b0;
				else
					pos++;
			end

			// Link state requested by the stimulus
			if (exp_valid_i) begin
				if (synced_i !== exp_synced_i)
					report_value("synced_o", exp_synced_i, synced_i);
				if ((mux_out_i & exp_mask_i) !== (exp_mux_i & exp_mask_i))
					report_value("mux_out_o", exp_mux_i & exp_mask_i, mux_out_i & exp_mask_i);
			end

			////////////////////////////////////////
			// Link hunt and bitslip prediction
			////////////////////////////////////////
			if (bitslip_i !== slip_exp)
				report_value("bitslip_o", slip_exp, bitslip_i);
			slip_next = 1'b0;
			if (lnk_synced) begin
				// Bit 7 must invert once the far end is live
				if (lnk_armed) begin
					if (mux_in_i[7] == lnk_expect) begin
						lnk_expect = !mux_in_i[7];
					end else begin
						lnk_armed = 1'b0;
						lnk_synced = 1'b0;
					end
				end else if (mux_in_i != SYNC_LOCK) begin
					lnk_armed = 1'b1;
					lnk_expect = !mux_in_i[7];
				end
			end else if (mux_in_i != SYNC_IDLE && mux_in_i != SYNC_LOCK) begin
				// Misaligned word, slip unless one is still recent
				lnk_lock = 1'b0;
				slip_next = !slip_exp && !slip_exp_d;
			end else begin
				if (mux_in_i == SYNC_LOCK && lnk_lock)
					lnk_synced = 1'b1;
				lnk_lock = 1'b1;
			end
			slip_exp_d = slip_exp;
			slip_exp = slip_next;
		end
		idle_o = !busy && (pri_q.size() == 0) && (sec_q.size() == 0);
	end

endmodule

//--- tests/tb_top.sv
module tb_top;

	localparam int PRI_WORDS = 4;
	localparam int SEC_WORDS = 8;
	localparam int FIFO_AW = 4;
	// Cycle limits for reset release and a drain
	localparam int RESET_LIMIT = 20;
	localparam int DRAIN_LIMIT = 2000;

	logic GMII_GTX_CLK_int;
	logic dsp_rst;
	logic [31:0] pri_data;
	logic pri_we;
	logic pri_ovf;
	logic [31:0] sec_data;
	logic sec_we;
	logic sec_ovf;
	logic [31:0] tx_data;
	logic [3:0] tx_flags;
	logic tx_src_rdy;
	logic tx_dst_rdy;
	logic [7:0] mux_in;
	logic [6:0] sw;
	logic [7:0] mux_out;
	logic bitslip;
	logic synced;
	// Expected link state for the checker
	logic exp_valid;
	logic exp_synced;
	logic [7:0] exp_mux;
	logic [7:0] exp_mask;
	logic model_idle;

	// 0 always ready, 1 LFSR driven, 2 stalled
	int bp_mode;
	logic [31:0] lfsr;
	int run_errs;

	tb_clock #(.PERIOD(10), .RST_CYCLES(4)) u_clock (
		.clk_o(GMII_GTX_CLK_int),
		.rst_o(dsp_rst)
	);

	eth_adc_top #(
		.PRI_PKT_WORDS(PRI_WORDS),
		.SEC_PKT_WORDS(SEC_WORDS),
		.FIFO_AW(FIFO_AW)
	) dut (
		.GMII_GTX_CLK_int(GMII_GTX_CLK_int),
		.dsp_rst(dsp_rst),
		.pri_data_i(pri_data),
		.pri_we_i(pri_we),
		.pri_ovf_o(pri_ovf),
		.sec_data_i(sec_data),
		.sec_we_i(sec_we),
		.sec_ovf_o(sec_ovf),
		.tx_data_o(tx_data),
		.tx_flags_o(tx_flags),
		.tx_src_rdy_o(tx_src_rdy),
		.tx_dst_rdy_i(tx_dst_rdy),
		.mux_in_i(mux_in),
		.sw_i(sw),
		.mux_out_o(mux_out),
		.bitslip_o(bitslip),
		.synced_o(synced)
	);

	tb_checker #(
		.PRI_WORDS(PRI_WORDS),
		.SEC_WORDS(SEC_WORDS),
		.DEPTH(1 << FIFO_AW)
	) u_checker (
		.clk_i(GMII_GTX_CLK_int),
		.rst_i(dsp_rst),
		.pri_we_i(pri_we),
		.pri_data_i(pri_data),
		.pri_ovf_i(pri_ovf),
		.sec_we_i(sec_we),
		.sec_data_i(sec_data),
		.sec_ovf_i(sec_ovf),
		.tx_data_i(tx_data),
		.tx_flags_i(tx_flags),
		.tx_src_rdy_i(tx_src_rdy),
		.tx_dst_rdy_i(tx_dst_rdy),
		.mux_in_i(mux_in),
		.bitslip_i(bitslip),
		.synced_i(synced),
		.mux_out_i(mux_out),
		.exp_valid_i(exp_valid),
		.exp_synced_i(exp_synced),
		.exp_mux_i(exp_mux),
		.exp_mask_i(exp_mask),
		.idle_o(model_idle)
	);

	// Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic update_ready();
		case (bp_mode)
			0: tx_dst_rdy = 1'b1;
			1: begin
				// One step per bit taken
				tx_dst_rdy = lfsr[0];
				lfsr = lfsr_next(lfsr);
			end
			default: tx_dst_rdy = 1'b0;
		endcase
	endtask

	// Inputs change 1 unit after the rising edge
	task automatic next_cycle();
		@(posedge GMII_GTX_CLK_int);
		#1;
		pri_we = 1'b0;
		sec_we = 1'b0;
		exp_valid = 1'b0;
		update_ready();
	endtask

	task automatic push_words(input bit to_sec, input logic [31:0] first, input int n);
		for (int i = 0; i < n; i++) begin
			next_cycle();
			if (to_sec) begin
				sec_we = 1'b1;
				sec_data = first + i;
			end else begin
				pri_we = 1'b1;
				pri_data = first + i;
			end
		end
	endtask

	// Wait for the model queues to empty
	task automatic drain_stream();
		int n;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (!model_idle && n < DRAIN_LIMIT);
		if (!model_idle) begin
			$display("Timeout: stream did not drain within %0d cycles in test %s",
				DRAIN_LIMIT, u_checker.test_name);
			run_errs++;
		end
	endtask

	initial begin
		int fd;
		int cnt;
		int wait_cnt;
		int assert_errs;
		int total;
		string line;
		string cmd;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		pri_data = '0;
		pri_we = 1'b0;
		sec_data = '0;
		sec_we = 1'b0;
		tx_dst_rdy = 1'b1;
		mux_in = '0;
		sw = '0;
		exp_valid = 1'b0;
		exp_synced = 1'b0;
		exp_mux = '0;
		exp_mask = '0;
		bp_mode = 0;
		lfsr = 32'hdefd_017e;
		run_errs = 0;

		// Reset release
		wait_cnt = 0;
		do begin
			@(posedge GMII_GTX_CLK_int);
			wait_cnt++;
		end while (dsp_rst !== 1'b0 && wait_cnt < RESET_LIMIT);
		if (dsp_rst !== 1'b0) begin
			$display("Timeout: reset never released");
			run_errs++;
		end
		#1;

		////////////////////////////////////////
		// Command loop
		////////////////////////////////////////
		fd = $fopen("tests/stimulus.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open tests/stimulus.txt");
			run_errs++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cmd = "";
				cnt = $fgets(line, fd);
				if (cnt > 0)
					cnt = $sscanf(line, "%s", cmd);
				// Blank lines and comments skipped
				if (cnt == 1 && cmd.getc(0) != "#") begin
					a = '0;
					b = '0;
					c = '0;
					if (cmd == "T") begin
						cnt = $sscanf(line, "%s %s", cmd, name);
						u_checker.test_name = name;
					end else begin
						cnt = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
						if (cmd == "P" || cmd == "S") begin
							push_words(cmd == "S", a, b);
						end else if (cmd == "B") begin
							bp_mode = a;
							update_ready();
						end else if (cmd == "M") begin
							for (int i = 0; i < b; i++) begin
								next_cycle();
								mux_in = a[7:0];
							end
						end else if (cmd == "W") begin
							sw = a[6:0];
						end else if (cmd == "E") begin
							next_cycle();
							exp_valid = 1'b1;
							exp_synced = a[0];
							exp_mux = b[7:0];
							exp_mask = c[7:0];
						end else if (cmd == "D") begin
							drain_stream();
						end else begin
							$display("Error: unknown stimulus command %s", cmd);
							run_errs++;
						end
					end
				end
			end
			$fclose(fd);
		end

		// Let the last comparisons happen
		next_cycle();
		next_cycle();

		assert_errs = dut.u_packet_sender.u_props_tx.fail_cnt
			+ dut.u_link_sync.u_props_link.fail_cnt;
		total = u_checker.value_errs + u_checker.proto_errs + run_errs + assert_errs;
		$display("Errors: value %0d, protocol %0d, run %0d, assertion %0d",
			u_checker.value_errs, u_checker.proto_errs, run_errs, assert_errs);
		if (total == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- tests/stimulus.txt
# cmd then hex fields: T name | P/S first count | B mode (0 ready, 1 lfsr, 2 stall)
# M word cycles | W switches | E synced mux mask | D drain
T sec_alone
S a000 8
D
T priority
B 2
P c000 4
S a100 8
P c100 4
B 0
D
T backpressure
B 1
P c200 8
S a200 10
D
B 0
T overflow
B 2
P c300 12
B 0
D
T link_acquire
W 55
M 3c 6
E 0 01 ff
M 01 2
E 0 81 ff
M 81 3
E 1 55 7f
T link_loss
M 00 1
M 80 1
M 80 1
E 0 81 ff
E 0 01 ff

//--- list.f
verilog/link_pkg.sv
verilog/word_fifo.sv
verilog/packet_sender.sv
verilog/link_sync.sv
verilog/eth_adc_top.sv
tests/tb_props.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv
